/* hw/rvj1_isa_pkg.sv */
// RV32I instruction encoding
// Major opcodes, funct3 and funct7 codes and the instruction width
// Only OP and OP-IMM classes are covered
`default_nettype none

package rvj1_isa_pkg;

  // Instruction width
  localparam int unsigned ILEN = 32;

  ////////////////////
  // Major opcodes
  ////////////////////
  typedef enum logic [6:0] {
    // Register-register
    OPC_OP     = 7'b0110011,
    // Register-immediate
    OPC_OP_IMM = 7'b0010011
  } opcode_e;

  ////////////////////
  // funct3 codes
  ////////////////////
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  // SRL and SRA share this code
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // Alternate funct7, selects SUB and SRA
  localparam logic [6:0] F7_ALT = 7'b0100000;

endpackage

`default_nettype wire

/* hw/rvj1_core_pkg.sv */
// Execute core definitions
// Datapath width, register file geometry and ALU operation codes
`default_nettype none

package rvj1_core_pkg;

  // Datapath width
  localparam int unsigned XLEN      = 32;
  // Register file geometry
  localparam int unsigned REG_COUNT = 32;
  localparam int unsigned REG_AW    = 5;
  // Shift amount bits taken from operand B
  localparam int unsigned SHAMT_W   = 5;

  ////////////////////
  // ALU operations
  ////////////////////
  typedef enum logic [3:0] {
    ALU_OP_ADD,
    ALU_OP_SUB,
    ALU_OP_XOR,
    ALU_OP_OR,
    ALU_OP_AND,
    ALU_OP_SLT,
    ALU_OP_SLTU,
    ALU_OP_SLL,
    ALU_OP_SRL,
    ALU_OP_SRA
  } alu_op_e;

endpackage

`default_nettype wire

/* hw/rvj1_decoder.sv */
// RV32I OP / OP-IMM decoder
// Maps an instruction to an ALU operation, register addresses and operands
// Anything outside OP and OP-IMM is flagged illegal
// Purely combinational
`timescale 1ns/10ps
`default_nettype none

module rvj1_decoder (
  input  logic [rvj1_isa_pkg::ILEN-1:0]    instr_i,
  output logic [rvj1_core_pkg::REG_AW-1:0] rs1_addr_o,
  output logic [rvj1_core_pkg::REG_AW-1:0] rs2_addr_o,
  input  logic [rvj1_core_pkg::XLEN-1:0]   rs1_data_i,
  input  logic [rvj1_core_pkg::XLEN-1:0]   rs2_data_i,
  output rvj1_core_pkg::alu_op_e           op_o,
  output logic [rvj1_core_pkg::XLEN-1:0]   op_a_o,
  output logic [rvj1_core_pkg::XLEN-1:0]   op_b_o,
  output logic [rvj1_core_pkg::REG_AW-1:0] rd_o,
  output logic                             illegal_o
);

  // Instruction fields
  logic [6:0]                      opcode;
  logic [2:0]                      funct3;
  logic [6:0]                      funct7;
  logic [rvj1_core_pkg::XLEN-1:0]  imm_i;
  logic                            is_op;
  logic                            is_op_imm;
  logic                            alt;

  assign opcode     = instr_i[6:0];
  assign rd_o       = instr_i[11:7];
  assign funct3     = instr_i[14:12];
  assign rs1_addr_o = instr_i[19:15];
  assign rs2_addr_o = instr_i[24:20];
  assign funct7     = instr_i[31:25];

  // Sign-extended I-immediate
  assign imm_i = {{(rvj1_core_pkg::XLEN-12){instr_i[31]}}, instr_i[31:20]};

  assign is_op     = (opcode == rvj1_isa_pkg::OPC_OP);
  assign is_op_imm = (opcode == rvj1_isa_pkg::OPC_OP_IMM);
  assign alt       = (funct7 == rvj1_isa_pkg::F7_ALT);

  // Operand A is always rs1
  assign op_a_o = rs1_data_i;
  // Immediate replaces rs2 for OP-IMM
  assign op_b_o = is_op_imm ? imm_i : rs2_data_i;

  ////////////////////
  // Operation select
  ////////////////////
  always_comb
  begin
    op_o = rvj1_core_pkg::ALU_OP_ADD;
    case (funct3)
      rvj1_isa_pkg::F3_ADD:
      begin
        // SUB only exists in register form
        if (is_op && alt)
          op_o = rvj1_core_pkg::ALU_OP_SUB;
      end
      rvj1_isa_pkg::F3_SLL:  op_o = rvj1_core_pkg::ALU_OP_SLL;
      rvj1_isa_pkg::F3_SLT:  op_o = rvj1_core_pkg::ALU_OP_SLT;
      rvj1_isa_pkg::F3_SLTU: op_o = rvj1_core_pkg::ALU_OP_SLTU;
      rvj1_isa_pkg::F3_XOR:  op_o = rvj1_core_pkg::ALU_OP_XOR;
      rvj1_isa_pkg::F3_SR:
      begin
        if (alt)
          op_o = rvj1_core_pkg::ALU_OP_SRA;
        else
          op_o = rvj1_core_pkg::ALU_OP_SRL;
      end
      rvj1_isa_pkg::F3_OR:   op_o = rvj1_core_pkg::ALU_OP_OR;
      default:               op_o = rvj1_core_pkg::ALU_OP_AND;
    endcase
  end

  ////////////////////
  // Illegal detection
  ////////////////////
  always_comb
  begin
    illegal_o = 1'b0;
    if (is_op)
    begin
      // funct7 must be zero or the alternate code
      if (funct7 != 7'd0 && !alt)
        illegal_o = 1'b1;
      // Alternate code valid for SUB and SRA only
      else if (alt && funct3 != rvj1_isa_pkg::F3_ADD && funct3 != rvj1_isa_pkg::F3_SR)
        illegal_o = 1'b1;
    end
    else if (is_op_imm)
    begin
      // SLLI needs a clean upper field
      if (funct3 == rvj1_isa_pkg::F3_SLL && funct7 != 7'd0)
        illegal_o = 1'b1;
      // SRLI / SRAI
      else if (funct3 == rvj1_isa_pkg::F3_SR && funct7 != 7'd0 && !alt)
        illegal_o = 1'b1;
    end
    else
      illegal_o = 1'b1;
  end

endmodule

`default_nettype wire

/* hw/rvj1_regfile.sv */
// Integer register file
// 32 entries, x0 reads zero and ignores writes
// Two combinational read ports with bypass of the current write
`timescale 1ns/10ps
`default_nettype none

module rvj1_regfile (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic [rvj1_core_pkg::REG_AW-1:0] rs1_addr_i,
  input  logic [rvj1_core_pkg::REG_AW-1:0] rs2_addr_i,
  output logic [rvj1_core_pkg::XLEN-1:0]   rs1_data_o,
  output logic [rvj1_core_pkg::XLEN-1:0]   rs2_data_o,
  input  logic                             wb_en_i,
  input  logic [rvj1_core_pkg::REG_AW-1:0] wb_addr_i,
  input  logic [rvj1_core_pkg::XLEN-1:0]   wb_data_i
);

  // x0 is not stored
  logic [rvj1_core_pkg::XLEN-1:0] regs_q [1:rvj1_core_pkg::REG_COUNT-1];

  // Read with x0 and write bypass
  function automatic logic [rvj1_core_pkg::XLEN-1:0] read_port(
    input logic [rvj1_core_pkg::REG_AW-1:0] addr
  );
    if (addr == '0)
      return '0;
    else if (wb_en_i && wb_addr_i == addr)
      return wb_data_i;
    else
      return regs_q[addr];
  endfunction

  always_comb
  begin
    rs1_data_o = read_port(rs1_addr_i);
    rs2_data_o = read_port(rs2_addr_i);
  end

  ////////////////////
  // Write port
  ////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 1; i < rvj1_core_pkg::REG_COUNT; i++)
        regs_q[i] <= '0;
    end
    else if (wb_en_i && wb_addr_i != '0)
      regs_q[wb_addr_i] <= wb_data_i;
  end

endmodule

`default_nettype wire

/* hw/rvj1_alu.sv */
// Arithmetic logic unit
// Ten RV32I integer operations feeding a one-entry output stage
// Owns the result handshake and the write-back enable
`timescale 1ns/10ps
`default_nettype none

module rvj1_alu (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             in_valid_i,
  output logic                             in_ready_o,
  input  rvj1_core_pkg::alu_op_e           op_i,
  input  logic [rvj1_core_pkg::XLEN-1:0]   op_a_i,
  input  logic [rvj1_core_pkg::XLEN-1:0]   op_b_i,
  input  logic [rvj1_core_pkg::REG_AW-1:0] rd_i,
  input  logic                             illegal_i,
  output logic                             res_valid_o,
  input  logic                             res_ready_i,
  output logic [rvj1_core_pkg::XLEN-1:0]   res_o,
  output logic [rvj1_core_pkg::REG_AW-1:0] rd_o,
  output logic                             illegal_o,
  output logic                             wb_en_o
);

  logic [rvj1_core_pkg::XLEN-1:0]    result;
  logic [rvj1_core_pkg::SHAMT_W-1:0] shamt;
  logic                              lt_s;
  logic                              lt_u;
  logic                              accept;

  assign shamt = op_b_i[rvj1_core_pkg::SHAMT_W-1:0];
  assign lt_u  = (op_a_i < op_b_i);

  // Signed compare, sign bits decide when they differ
  always_comb
  begin
    case ({op_a_i[rvj1_core_pkg::XLEN-1], op_b_i[rvj1_core_pkg::XLEN-1]})
      2'b10:   lt_s = 1'b1;
      2'b01:   lt_s = 1'b0;
      default: lt_s = lt_u;
    endcase
  end

  ////////////////////
  // Result mux
  ////////////////////
  always_comb
  begin
    case (op_i)
      rvj1_core_pkg::ALU_OP_ADD:  result = op_a_i + op_b_i;
      rvj1_core_pkg::ALU_OP_SUB:  result = op_a_i - op_b_i;
      rvj1_core_pkg::ALU_OP_XOR:  result = op_a_i ^ op_b_i;
      rvj1_core_pkg::ALU_OP_OR:   result = op_a_i | op_b_i;
      rvj1_core_pkg::ALU_OP_AND:  result = op_a_i & op_b_i;
      rvj1_core_pkg::ALU_OP_SLT:  result = {{(rvj1_core_pkg::XLEN-1){1'b0}}, lt_s};
      rvj1_core_pkg::ALU_OP_SLTU: result = {{(rvj1_core_pkg::XLEN-1){1'b0}}, lt_u};
      rvj1_core_pkg::ALU_OP_SLL:  result = op_a_i << shamt;
      rvj1_core_pkg::ALU_OP_SRL:  result = op_a_i >> shamt;
      rvj1_core_pkg::ALU_OP_SRA:  result = $signed(op_a_i) >>> shamt;
      default:                    result = '0;
    endcase
  end

  ////////////////////
  // Output stage
  ////////////////////
  // Stage can take a new entry when empty or draining
  assign in_ready_o = !res_valid_o || res_ready_i;
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      res_valid_o <= 1'b0;
      res_o       <= '0;
      rd_o        <= '0;
      illegal_o   <= 1'b0;
    end
    else if (accept)
    begin
      res_valid_o <= 1'b1;
      // Illegal entries carry zero
      res_o       <= illegal_i ? '0 : result;
      rd_o        <= rd_i;
      illegal_o   <= illegal_i;
    end
    else if (res_ready_i)
      res_valid_o <= 1'b0;
  end

  // Write back on a legal result handshake
  assign wb_en_o = res_valid_o && res_ready_i && !illegal_o;

endmodule

`default_nettype wire

/* hw/rvj1_exec_top.sv */
// RV32I integer execute subsystem
// Decoder, register file and ALU behind two valid/ready channels
// One cycle from instruction accept to result valid
// Results write back to the register file on the output handshake
`timescale 1ns/10ps
`default_nettype none

module rvj1_exec_top (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  // Instruction channel
  input  logic                             instr_valid_i,
  output logic                             instr_ready_o,
  input  logic [rvj1_isa_pkg::ILEN-1:0]    instr_i,
  // Result channel
  output logic                             res_valid_o,
  input  logic                             res_ready_i,
  output logic [rvj1_core_pkg::XLEN-1:0]   res_data_o,
  output logic [rvj1_core_pkg::REG_AW-1:0] res_rd_o,
  output logic                             res_illegal_o
);

  ////////////////////
  // Internal wires
  ////////////////////
  // Register read path
  logic [rvj1_core_pkg::REG_AW-1:0] rs1_addr;
  logic [rvj1_core_pkg::REG_AW-1:0] rs2_addr;
  logic [rvj1_core_pkg::XLEN-1:0]   rs1_data;
  logic [rvj1_core_pkg::XLEN-1:0]   rs2_data;
  // Decoded operation
  rvj1_core_pkg::alu_op_e           alu_op;
  logic [rvj1_core_pkg::XLEN-1:0]   op_a;
  logic [rvj1_core_pkg::XLEN-1:0]   op_b;
  logic [rvj1_core_pkg::REG_AW-1:0] dec_rd;
  logic                             dec_illegal;
  // Write-back strobe
  logic                             wb_en;

  rvj1_decoder u_decoder (
    .instr_i    (instr_i),
    .rs1_addr_o (rs1_addr),
    .rs2_addr_o (rs2_addr),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .op_o       (alu_op),
    .op_a_o     (op_a),
    .op_b_o     (op_b),
    .rd_o       (dec_rd),
    .illegal_o  (dec_illegal)
  );

  // Write-back address and data come straight from the result stage
  rvj1_regfile u_regfile (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wb_en_i    (wb_en),
    .wb_addr_i  (res_rd_o),
    .wb_data_i  (res_data_o)
  );

  rvj1_alu u_alu (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (instr_valid_i),
    .in_ready_o  (instr_ready_o),
    .op_i        (alu_op),
    .op_a_i      (op_a),
    .op_b_i      (op_b),
    .rd_i        (dec_rd),
    .illegal_i   (dec_illegal),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .res_o       (res_data_o),
    .rd_o        (res_rd_o),
    .illegal_o   (res_illegal_o),
    .wb_en_o     (wb_en)
  );

endmodule

`default_nettype wire

/* tb/rvj1_exec_properties.sv */
// ALU output stage properties
// Reset state, handshake stability and write-back qualification
`timescale 1ns/10ps
`default_nettype none

module rvj1_exec_properties (
  input logic                             clk_i,
  input logic                             rst_n_i,
  input logic                             res_valid_o,
  input logic                             res_ready_i,
  input logic [rvj1_core_pkg::XLEN-1:0]   res_o,
  input logic [rvj1_core_pkg::REG_AW-1:0] rd_o,
  input logic                             illegal_o,
  input logic                             wb_en_o
);

  // Output stage empty while in reset
  a_reset_empty: assert property (@(posedge clk_i) !rst_n_i |-> !res_valid_o)
    else $error("res_valid_o high during reset");

  // Held entry frozen under back-pressure
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_o) && $stable(rd_o)
      && $stable(illegal_o))
    else $error("held result changed under back-pressure");

  // Write back only on a legal handshake
  a_wb_qualified: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_en_o |-> res_valid_o && res_ready_i && !illegal_o)
    else $error("write-back outside a legal result handshake");

endmodule

`default_nettype wire

/* tb/rvj1_exec_tb.sv */
// Testbench for the RV32I execute subsystem
// Table of OP / OP-IMM instructions checked against a register model
// Random back-pressure on the result channel
`timescale 1ns/10ps
`default_nettype none

module rvj1_exec_tb;

  localparam int unsigned MAX_WAIT = 200;

  logic                             clk_i;
  logic                             rst_n_i;
  logic                             instr_valid_i;
  logic                             instr_ready_o;
  logic [rvj1_isa_pkg::ILEN-1:0]    instr_i;
  logic                             res_valid_o;
  logic                             res_ready_i;
  logic [rvj1_core_pkg::XLEN-1:0]   res_data_o;
  logic [rvj1_core_pkg::REG_AW-1:0] res_rd_o;
  logic                             res_illegal_o;

  // Stimulus table and expected illegal flags
  logic [31:0] instr_tbl [$];
  logic        ill_tbl [$];
  // Architectural register state as seen by the results
  logic [31:0] reg_model [32];
  int          res_idx;
  int          n_checks;
  int          n_errors;
  int          n_timeouts;
  logic [15:0] lfsr_q;

  rvj1_exec_top dut (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_ready_o (instr_ready_o),
    .instr_i       (instr_i),
    .res_valid_o   (res_valid_o),
    .res_ready_i   (res_ready_i),
    .res_data_o    (res_data_o),
    .res_rd_o      (res_rd_o),
    .res_illegal_o (res_illegal_o)
  );

  bind rvj1_alu rvj1_exec_properties u_props (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .res_o       (res_o),
    .rd_o        (rd_o),
    .illegal_o   (illegal_o),
    .wb_en_o     (wb_en_o)
  );

  always #5 clk_i = ~clk_i;

  ////////////////////
  // Helpers
  ////////////////////
  // x^16 + x^14 + x^13 + x^11, one step per bit
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] enc_reg(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rvj1_isa_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] enc_imm(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, rvj1_isa_pkg::OPC_OP_IMM};
  endfunction

  // Expected value from the RV32I rules and the register model
  function automatic logic [31:0] expected_result(input logic [31:0] w);
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  sh;
    logic        imm_form;
    logic [31:0] r;
    imm_form = (w[6:0] == rvj1_isa_pkg::OPC_OP_IMM);
    a        = reg_model[w[19:15]];
    b        = imm_form ? {{20{w[31]}}, w[31:20]} : reg_model[w[24:20]];
    sh       = b[4:0];
    case (w[14:12])
      rvj1_isa_pkg::F3_ADD:  r = (!imm_form && w[30]) ? a - b : a + b;
      rvj1_isa_pkg::F3_SLL:  r = a << sh;
      rvj1_isa_pkg::F3_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      rvj1_isa_pkg::F3_SLTU: r = (a < b) ? 32'd1 : 32'd0;
      rvj1_isa_pkg::F3_XOR:  r = a ^ b;
      rvj1_isa_pkg::F3_OR:   r = a | b;
      rvj1_isa_pkg::F3_AND:  r = a & b;
      default:
      begin
        // Arithmetic shift replicates bit 31
        if (w[30])
          r = $signed(a) >>> sh;
        else
          r = a >> sh;
      end
    endcase
    return r;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic add_entry(input logic [31:0] word, input logic illegal);
    instr_tbl.push_back(word);
    ill_tbl.push_back(illegal);
  endtask

  ////////////////////
  // Result side
  ////////////////////
  task automatic collect_result();
    logic [31:0] word;
    logic [31:0] exp;
    logic        ill;
    if (res_idx >= instr_tbl.size())
    begin
      n_errors++;
      $display("Result at %0t ns arrived with no instruction outstanding", $time);
    end
    else
    begin
      word = instr_tbl[res_idx];
      ill  = ill_tbl[res_idx];
      exp  = ill ? 32'd0 : expected_result(word);
      check_value("illegal flag", res_illegal_o, ill);
      check_value("rd", res_rd_o, word[11:7]);
      check_value("result", res_data_o, exp);
      // x0 never changes
      if (!ill && word[11:7] != 5'd0)
        reg_model[word[11:7]] = exp;
      res_idx++;
    end
  endtask

  // Values sampled here are the ones present before the edge
  always @(posedge clk_i)
  begin
    if (rst_n_i)
    begin
      if (res_valid_o && res_ready_i)
        collect_result();
      res_ready_i <= lfsr_bit();
    end
  end

  ////////////////////
  // Instruction side
  ////////////////////
  task automatic wait_accept(input int idx);
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < MAX_WAIT)
    begin
      @(posedge clk_i);
      done = instr_ready_o;
      cycles++;
    end
    if (!done)
    begin
      n_timeouts++;
      $display("Timeout: instruction %0d was never accepted", idx);
    end
  endtask

  task automatic wait_results();
    int cycles;
    cycles = 0;
    while (res_idx < instr_tbl.size() && cycles < MAX_WAIT)
    begin
      @(posedge clk_i);
      cycles++;
    end
    if (res_idx < instr_tbl.size())
    begin
      n_timeouts++;
      $display("Timeout: only %0d of %0d results came back", res_idx, instr_tbl.size());
    end
  endtask

  task automatic build_table();
    // Constants, then wrapping add and subtract
    add_entry(enc_imm(12'd100, 5'd0, rvj1_isa_pkg::F3_ADD, 5'd1), 1'b0);
    add_entry(enc_imm(12'hFF9, 5'd0, rvj1_isa_pkg::F3_ADD, 5'd2), 1'b0);
    add_entry(enc_imm(12'h7FF, 5'd0, rvj1_isa_pkg::F3_ADD, 5'd3), 1'b0);
    add_entry(enc_reg(7'd0, 5'd2, 5'd1, rvj1_isa_pkg::F3_ADD, 5'd4), 1'b0);
    add_entry(enc_reg(rvj1_isa_pkg::F7_ALT, 5'd1, 5'd2, rvj1_isa_pkg::F3_ADD, 5'd5), 1'b0);
    add_entry(enc_imm(12'd21, 5'd3, rvj1_isa_pkg::F3_SLL, 5'd6), 1'b0);
    add_entry(enc_reg(7'd0, 5'd6, 5'd6, rvj1_isa_pkg::F3_ADD, 5'd7), 1'b0);
    add_entry(enc_reg(rvj1_isa_pkg::F7_ALT, 5'd6, 5'd0, rvj1_isa_pkg::F3_ADD, 5'd8), 1'b0);
    // Bitwise, both forms
    add_entry(enc_reg(7'd0, 5'd2, 5'd1, rvj1_isa_pkg::F3_XOR, 5'd9), 1'b0);
    add_entry(enc_reg(7'd0, 5'd6, 5'd1, rvj1_isa_pkg::F3_OR, 5'd10), 1'b0);
    add_entry(enc_reg(7'd0, 5'd2, 5'd3, rvj1_isa_pkg::F3_AND, 5'd11), 1'b0);
    add_entry(enc_imm(12'hA5A, 5'd1, rvj1_isa_pkg::F3_XOR, 5'd12), 1'b0);
    add_entry(enc_imm(12'h0F0, 5'd2, rvj1_isa_pkg::F3_OR, 5'd12), 1'b0);
    add_entry(enc_imm(12'hF0F, 5'd6, rvj1_isa_pkg::F3_AND, 5'd12), 1'b0);
    // Mixed-sign compares
    add_entry(enc_reg(7'd0, 5'd1, 5'd2, rvj1_isa_pkg::F3_SLT, 5'd13), 1'b0);
    add_entry(enc_reg(7'd0, 5'd1, 5'd2, rvj1_isa_pkg::F3_SLTU, 5'd14), 1'b0);
    add_entry(enc_imm(12'hFFF, 5'd1, rvj1_isa_pkg::F3_SLT, 5'd15), 1'b0);
    add_entry(enc_imm(12'hFFF, 5'd1, rvj1_isa_pkg::F3_SLTU, 5'd16), 1'b0);
    // Shift by 35 uses only the low 5 bits
    add_entry(enc_imm(12'd35, 5'd0, rvj1_isa_pkg::F3_ADD, 5'd18), 1'b0);
    add_entry(enc_reg(7'd0, 5'd18, 5'd1, rvj1_isa_pkg::F3_SLL, 5'd19), 1'b0);
    add_entry(enc_reg(7'd0, 5'd18, 5'd2, rvj1_isa_pkg::F3_SR, 5'd20), 1'b0);
    add_entry(enc_reg(rvj1_isa_pkg::F7_ALT, 5'd18, 5'd2, rvj1_isa_pkg::F3_SR, 5'd21), 1'b0);
    add_entry(enc_imm({rvj1_isa_pkg::F7_ALT, 5'd4}, 5'd6, rvj1_isa_pkg::F3_SR, 5'd22), 1'b0);
    add_entry(enc_imm(12'd4, 5'd6, rvj1_isa_pkg::F3_SR, 5'd23), 1'b0);
    // Dependent chain through the bypass, then x0
    add_entry(enc_imm(12'd1, 5'd24, rvj1_isa_pkg::F3_ADD, 5'd24), 1'b0);
    add_entry(enc_imm(12'd1, 5'd24, rvj1_isa_pkg::F3_ADD, 5'd24), 1'b0);
    add_entry(enc_reg(7'd0, 5'd24, 5'd24, rvj1_isa_pkg::F3_ADD, 5'd24), 1'b0);
    add_entry(enc_imm(12'd123, 5'd0, rvj1_isa_pkg::F3_ADD, 5'd0), 1'b0);
    add_entry(enc_reg(7'd0, 5'd0, 5'd0, rvj1_isa_pkg::F3_ADD, 5'd25), 1'b0);
    // Illegal encodings aimed at x1, then x1 read back
    add_entry({20'h12345, 5'd1, 7'b0110111}, 1'b1);
    add_entry(enc_reg(7'b0000001, 5'd2, 5'd1, rvj1_isa_pkg::F3_ADD, 5'd1), 1'b1);
    add_entry(enc_reg(rvj1_isa_pkg::F7_ALT, 5'd2, 5'd1, rvj1_isa_pkg::F3_XOR, 5'd1), 1'b1);
    add_entry(enc_imm({rvj1_isa_pkg::F7_ALT, 5'd3}, 5'd1, rvj1_isa_pkg::F3_SLL, 5'd1), 1'b1);
    add_entry(enc_imm(12'd0, 5'd1, rvj1_isa_pkg::F3_ADD, 5'd26), 1'b0);
  endtask

  initial
  begin
    clk_i         = 1'b0;
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    res_ready_i   = 1'b0;
    lfsr_q        = 16'd39;
    res_idx       = 0;
    n_checks      = 0;
    n_errors      = 0;
    n_timeouts    = 0;
    for (int r = 0; r < 32; r++)
      reg_model[r] = '0;
    build_table();

    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    check_value("res_valid_o after reset", res_valid_o, 1'b0);
    check_value("instr_ready_o after reset", instr_ready_o, 1'b1);

    // Next word goes out on the edge of the previous handshake
    for (int i = 0; i < instr_tbl.size(); i++)
    begin
      instr_valid_i <= 1'b1;
      instr_i       <= instr_tbl[i];
      wait_accept(i);
      if (n_timeouts != 0)
        break;
    end
    instr_valid_i <= 1'b0;
    if (n_timeouts == 0)
      wait_results();

    $display("Checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
hw/rvj1_isa_pkg.sv
hw/rvj1_core_pkg.sv
hw/rvj1_decoder.sv
hw/rvj1_regfile.sv
hw/rvj1_alu.sv
hw/rvj1_exec_top.sv
tb/rvj1_exec_properties.sv
tb/rvj1_exec_tb.sv

/* Bender.yml */
package:
  name: rvj1_exec

sources:
  # RTL
  - files:
      - hw/rvj1_isa_pkg.sv
      - hw/rvj1_core_pkg.sv
      - hw/rvj1_decoder.sv
      - hw/rvj1_regfile.sv
      - hw/rvj1_alu.sv
      - hw/rvj1_exec_top.sv
  # Testbench
  - target: simulation
    files:
      - tb/rvj1_exec_properties.sv
      - tb/rvj1_exec_tb.sv
